// File: src/lc3b_pkg.sv
package lc3b_pkg;

    // ##############################
    // Data path widths
    // ##############################

    typedef logic [15:0]  lc3b_word;       // Data and address word.
    typedef logic [2:0]   lc3b_cc;         // N, Z, P.
    typedef logic [1:0]   lc3b_mux_sel;    // Three way source select.
    typedef logic [1:0]   lc3b_byte_sel;   // Bit 1 high byte, bit 0 low byte.

    // ##############################
    // Line memory bus widths
    // ##############################

    typedef logic [127:0] lc3b_line;       // Eight words per line.
    typedef logic [15:0]  lc3b_line_sel;   // One enable per byte of a line.
    typedef logic [11:0]  lc3b_line_addr;  // Word address bits 15 to 4.

    // Address source select values.
    localparam lc3b_mux_sel addr_src_trap = 2'd0;
    localparam lc3b_mux_sel addr_src_alu  = 2'd1;
    localparam lc3b_mux_sel addr_src_mdr  = 2'd2;

    // Condition code source select values.
    localparam lc3b_mux_sel cc_src_alu = 2'd0;
    localparam lc3b_mux_sel cc_src_mdr = 2'd1;
    localparam lc3b_mux_sel cc_src_sr2 = 2'd2;

    localparam lc3b_cc cc_neg  = 3'b100;   // Negative.
    localparam lc3b_cc cc_zero = 3'b010;   // Zero.
    localparam lc3b_cc cc_pos  = 3'b001;   // Positive.

    // Stage sequencing.
    typedef enum logic [1:0] {
        st_idle,                           // Waiting for an operation.
        st_bus,                            // Bus cycle open.
        st_done                            // Result cycle.
    } mem_state_e;

endpackage

// File: src/wishbone_if.sv
`timescale 1ns/1ps

interface wishbone_if import lc3b_pkg::*; ();

    lc3b_line_addr adr;    // Line address.
    lc3b_line      dat_m;  // Write data from the master.
    lc3b_line      dat_s;  // Read data from the slave.
    lc3b_line_sel  sel;    // Byte enables.
    logic          we;     // Write cycle.
    logic          cyc;    // Cycle in progress.
    logic          stb;    // Transfer strobe.
    logic          ack;    // Slave acknowledge.

    modport master (
        output adr,
        output dat_m,
        output sel,
        output we,
        output cyc,
        output stb,
        input  dat_s,
        input  ack
    );

    modport slave (
        input  adr,
        input  dat_m,
        input  sel,
        input  we,
        input  cyc,
        input  stb,
        output dat_s,
        output ack
    );

endinterface

// File: src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import lc3b_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         op_valid,
    input  logic         mem_read,
    input  logic         mem_write,
    input  lc3b_byte_sel byte_sel,
    input  lc3b_mux_sel  addr_sel,
    input  lc3b_mux_sel  gencc_sel,
    input  logic         cc_load,
    input  logic         mdr_load,
    input  lc3b_word     alu_in,
    input  lc3b_word     ir_in,
    input  lc3b_word     sr2_in,
    output lc3b_cc       cc,
    output lc3b_word     mdr,
    output logic         busy,
    output logic         done,
    wishbone_if.master   data_bus
);

    mem_state_e   state;
    mem_state_e   state_next;
    logic         accept;
    logic         op_read_q;
    logic         op_write_q;
    logic         cc_load_q;
    logic         mdr_load_q;
    logic         cc_from_mdr_q;
    lc3b_byte_sel byte_sel_q;
    lc3b_word     addr_q;
    lc3b_word     store_q;
    lc3b_word     cc_word_q;
    lc3b_word     rd_word;
    lc3b_word     ind_mdr;
    lc3b_word     ind_fwd;
    lc3b_word     trap_vect;
    lc3b_word     addr_mux;
    lc3b_word     mdr_next;
    lc3b_word     cc_word;
    lc3b_cc       cc_next;
    logic [2:0]   lane;

    // ##############################
    // Operation accept and address
    // ##############################

    assign accept    = op_valid && (state != st_bus);   // Busy only in bus state.
    assign trap_vect = {7'b0, ir_in[7:0], 1'b0};         // Trap table entry.
    assign mdr_next  = op_read_q ? rd_word : mdr;        // Word the result edge loads.

    // An indirect register load at the result edge is forwarded to a
    // back-to-back access that selects it.
    assign ind_fwd = (state == st_done && mdr_load_q) ? mdr_next : ind_mdr;

    always_comb begin
        case (addr_sel)
            addr_src_trap: addr_mux = trap_vect;
            addr_src_mdr:  addr_mux = ind_fwd;
            default:       addr_mux = alu_in;            // ALU result.
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            st_bus: begin
                if (data_bus.ack) begin
                    state_next = st_done;                // Ack closes the cycle.
                end
            end
            default: begin
                if (accept) begin
                    state_next = (mem_read || mem_write) ? st_bus : st_done;
                end else begin
                    state_next = st_idle;
                end
            end
        endcase
    end

    // ##############################
    // Bus master side
    // ##############################

    assign lane          = addr_q[3:1];                  // Word within the line.
    assign data_bus.adr  = addr_q[15:4];
    assign data_bus.cyc  = (state == st_bus);
    assign data_bus.stb  = (state == st_bus);
    assign data_bus.we   = (state == st_bus) && op_write_q;

    always_comb begin
        data_bus.sel = '0;
        data_bus.sel[lane*2 +: 2] = byte_sel_q;           // Two enables per word.
        data_bus.dat_m = '0;
        data_bus.dat_m[lane*16 +: 16] = store_q;
    end

    // ##############################
    // Condition codes
    // ##############################

    always_comb begin
        cc_word = cc_from_mdr_q ? mdr_next : cc_word_q;
        if (cc_word[15]) begin
            cc_next = cc_neg;
        end else if (cc_word == '0) begin
            cc_next = cc_zero;
        end else begin
            cc_next = cc_pos;
        end
    end

    assign busy = (state == st_bus);
    assign done = (state == st_done);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= st_idle;
            op_read_q     <= 1'b0;
            op_write_q    <= 1'b0;
            cc_load_q     <= 1'b0;
            mdr_load_q    <= 1'b0;
            cc_from_mdr_q <= 1'b0;
            cc            <= '0;
            mdr           <= '0;
            ind_mdr       <= '0;
        end else begin
            state <= state_next;
            if (accept) begin
                op_read_q     <= mem_read;
                op_write_q    <= mem_write;
                cc_load_q     <= cc_load;
                mdr_load_q    <= mdr_load;
                cc_from_mdr_q <= (gencc_sel == cc_src_mdr);
            end
            if (state == st_done) begin                  // Results at end of done.
                if (op_read_q) begin
                    mdr <= rd_word;
                end
                if (cc_load_q) begin
                    cc <= cc_next;
                end
                if (mdr_load_q) begin
                    ind_mdr <= mdr_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q     <= addr_mux;
            store_q    <= sr2_in;
            byte_sel_q <= byte_sel;
            cc_word_q  <= (gencc_sel == cc_src_sr2) ? sr2_in : alu_in;
        end
        if (state == st_bus && data_bus.ack) begin
            rd_word <= data_bus.dat_s[lane*16 +: 16]; // Read data valid with ack.
        end
    end

endmodule

// File: src/data_memory.sv
`timescale 1ns/1ps

module data_memory import lc3b_pkg::*; #(
    parameter int mem_depth_log2 = 8
) (
    input  logic      clk,
    input  logic      arst_n,
    wishbone_if.slave data_bus
);

    localparam int mem_lines = 2 ** mem_depth_log2;
    localparam int line_bytes = $bits(lc3b_line_sel);

    lc3b_line                  mem_array [mem_lines];
    logic [mem_depth_log2-1:0] line_idx;
    logic                      req;

    // ##############################
    // Request decode
    // ##############################

    assign line_idx = data_bus.adr[mem_depth_log2-1:0];              // Wraps modulo depth.
    assign req      = data_bus.cyc && data_bus.stb && !data_bus.ack; // New strobe seen.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_bus.ack <= 1'b0;
        end else begin
            data_bus.ack <= req;                 // One cycle pulse.
        end
    end

    // ##############################
    // Line storage
    // ##############################

    always_ff @(posedge clk) begin
        if (req) begin
            data_bus.dat_s <= mem_array[line_idx]; // Whole line back.
            if (data_bus.we) begin
                for (int i = 0; i < line_bytes; i++) begin
                    if (data_bus.sel[i]) begin
                        mem_array[line_idx][8*i +: 8] <= data_bus.dat_m[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: src/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem import lc3b_pkg::*; #(
    parameter int mem_depth_log2 = 8
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         op_valid,   // Operation strobe.
    input  logic         mem_read,
    input  logic         mem_write,
    input  lc3b_byte_sel byte_sel,
    input  lc3b_mux_sel  addr_sel,
    input  lc3b_mux_sel  gencc_sel,
    input  logic         cc_load,
    input  logic         mdr_load,
    input  lc3b_word     alu_in,
    input  lc3b_word     ir_in,
    input  lc3b_word     sr2_in,
    output lc3b_cc       cc,
    output lc3b_word     mdr,
    output logic         busy,
    output logic         done
);

    // ##############################
    // Stage to memory bus
    // ##############################

    wishbone_if data_bus_if ();

    mem_stage mem_stage_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .byte_sel  (byte_sel),
        .addr_sel  (addr_sel),
        .gencc_sel (gencc_sel),
        .cc_load   (cc_load),
        .mdr_load  (mdr_load),
        .alu_in    (alu_in),
        .ir_in     (ir_in),
        .sr2_in    (sr2_in),
        .cc        (cc),
        .mdr       (mdr),
        .busy      (busy),
        .done      (done),
        .data_bus  (data_bus_if.master)
    );

    // Line memory with the depth passed down.
    data_memory #(
        .mem_depth_log2 (mem_depth_log2)
    ) data_memory_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .data_bus (data_bus_if.slave)
    );

endmodule

// File: testbench/mem_subsystem_properties.sv
`timescale 1ns/1ps

module mem_subsystem_properties (
    input logic clk,
    input logic arst_n,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic busy,
    input logic done
);

    // ##############################
    // Wishbone classic handshake
    // ##############################

    // Master holds the request until the slave answers.
    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        (cyc && stb && !ack) |=> (cyc && stb))
        else $error("cyc or stb dropped before ack");

    ack_needs_stb: assert property (@(posedge clk) disable iff (!arst_n) ack |-> stb)
        else $error("ack without stb");

    // ##############################
    // Stage status
    // ##############################

    ack_then_done: assert property (@(posedge clk) disable iff (!arst_n)
        ack |=> (done && !busy))
        else $error("done did not follow ack or busy stayed high");

    idle_in_reset: assert property (@(posedge clk) !arst_n |-> !cyc)
        else $error("cyc high during reset");

endmodule

bind mem_stage mem_subsystem_properties mem_stage_props_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .cyc    (data_bus.cyc),
    .stb    (data_bus.stb),
    .ack    (data_bus.ack),
    .busy   (busy),
    .done   (done)
);

// File: testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem import lc3b_pkg::*; ();

    localparam int depth_log2  = 8;
    localparam int model_words = 2 ** (depth_log2 + 3);  // Eight words per line.
    localparam int op_count    = 400;
    localparam int wait_limit  = 20;

    logic         clk;
    logic         arst_n;
    logic         op_valid;
    logic         mem_read;
    logic         mem_write;
    lc3b_byte_sel byte_sel;
    lc3b_mux_sel  addr_sel;
    lc3b_mux_sel  gencc_sel;
    logic         cc_load;
    logic         mdr_load;
    lc3b_word     alu_in;
    lc3b_word     ir_in;
    lc3b_word     sr2_in;
    lc3b_cc       cc;
    lc3b_word     mdr;
    logic         busy;
    logic         done;

    lc3b_word     model_mem [model_words];
    lc3b_byte_sel model_mask [model_words];     // Bytes written so far.
    lc3b_word     addr_pool [16];
    lc3b_word     mdr_m;
    lc3b_word     ind_m;
    lc3b_cc       cc_m;
    logic         mdr_ok;                       // Model value is known.
    logic         ind_ok;
    logic         cc_ok;
    logic         timed_out;
    logic [31:0]  lfsr;
    int           errors;
    int           latency;

    mem_subsystem #(.mem_depth_log2(depth_log2)) mem_subsystem_inst (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ##############################
    // Helpers
    // ##############################

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic lc3b_word pick_addr();
        if (rand_bits(2) != 0) begin
            return addr_pool[4'(rand_bits(4))];         // Mostly reuse hot words.
        end
        return lc3b_word'(rand_bits(depth_log2 + 4)) & 16'hfffe;
    endfunction

    function automatic lc3b_cc cc_of(input lc3b_word w);
        if (w[15]) begin
            return 3'b100;
        end else if (w == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    task automatic compare_value(input string name, input lc3b_word exp, input lc3b_word act);
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic drive_random_op();
        logic [1:0] kind;
        kind      = 2'(rand_bits(2));
        mem_write = (kind == 2'd1);
        mem_read  = kind[1];
        addr_sel  = lc3b_mux_sel'(rand_bits(2) % 3);
        if (addr_sel == 2'd2 && !ind_ok) begin
            addr_sel = 2'd1;                            // Pointer not known.
        end
        gencc_sel = lc3b_mux_sel'(rand_bits(2) % 3);
        cc_load   = rand_bits(1) != 0;
        mdr_load  = rand_bits(1) != 0;
        byte_sel  = 2'b11;
        if (mem_write && rand_bits(1) != 0) begin
            byte_sel = lc3b_byte_sel'(rand_bits(1) + 1); // Single byte.
        end
        alu_in = (addr_sel == 2'd1) ? pick_addr() : lc3b_word'(rand_bits(16));
        ir_in  = lc3b_word'(rand_bits(16));
        sr2_in = (rand_bits(1) != 0) ? pick_addr() : lc3b_word'(rand_bits(16));
        if (rand_bits(3) == 0) begin
            sr2_in = '0;
        end
    endtask

    task automatic issue_op();
        int cycles;
        cycles   = 1;
        op_valid = 1'b1;
        @(negedge clk);                                 // Accepted at the rising edge.
        op_valid = 1'b0;
        while (!done && cycles < wait_limit) begin
            compare_value("busy", 16'h0001, {15'b0, busy});  // High until done.
            @(negedge clk);
            cycles++;
        end
        latency = cycles;
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout at %0t: done never came after an operation", $time);
        end
        @(negedge clk);                                 // Results load as done ends.
    endtask

    task automatic model_and_check();
        lc3b_word addr;
        lc3b_word new_mdr;
        logic     new_ok;
        int       idx;
        case (addr_sel)
            2'd0:    addr = lc3b_word'(ir_in[7:0]) << 1;
            2'd2:    addr = ind_m;
            default: addr = alu_in;
        endcase
        idx     = int'(addr[depth_log2+3:1]);           // Line and lane together.
        new_mdr = mdr_m;
        new_ok  = mdr_ok;
        if (mem_write) begin
            if (byte_sel[0]) begin
                model_mem[idx][7:0] = sr2_in[7:0];
            end
            if (byte_sel[1]) begin
                model_mem[idx][15:8] = sr2_in[15:8];
            end
            model_mask[idx] = model_mask[idx] | byte_sel;
        end
        if (mem_read) begin
            new_mdr = model_mem[idx];
            new_ok  = (model_mask[idx] == 2'b11);
        end
        if (cc_load) begin
            case (gencc_sel)
                2'd1:    cc_m = cc_of(new_mdr);
                2'd2:    cc_m = cc_of(sr2_in);
                default: cc_m = cc_of(alu_in);
            endcase
            cc_ok = (gencc_sel == 2'd1) ? new_ok : 1'b1;
        end
        if (mdr_load) begin
            ind_m  = new_mdr;
            ind_ok = new_ok;
        end
        mdr_m  = new_mdr;
        mdr_ok = new_ok;
        compare_value("done_latency", (mem_read || mem_write) ? 16'd3 : 16'd1,
                      lc3b_word'(latency));
        if (mdr_ok) begin
            compare_value("mdr", mdr_m, mdr);
        end
        if (cc_ok) begin
            compare_value("cc", {13'b0, cc_m}, {13'b0, cc});
        end
    endtask

    // ##############################
    // Stimulus
    // ##############################

    initial begin
        lfsr      = 32'h6477889e;
        errors    = 0;
        timed_out = 1'b0;
        arst_n    = 1'b0;
        op_valid  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        byte_sel  = 2'b11;
        addr_sel  = 2'd1;
        gencc_sel = 2'd0;
        cc_load   = 1'b0;
        mdr_load  = 1'b0;
        alu_in    = '0;
        ir_in     = '0;
        sr2_in    = '0;
        mdr_m     = '0;
        ind_m     = '0;
        cc_m      = '0;
        mdr_ok    = 1'b1;
        ind_ok    = 1'b1;
        cc_ok     = 1'b1;
        for (int i = 0; i < model_words; i++) begin
            model_mask[i] = 2'b00;
        end
        for (int i = 0; i < 16; i++) begin
            addr_pool[i] = lc3b_word'(rand_bits(depth_log2 + 4)) & 16'hfffe;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        compare_value("cc", 16'h0000, {13'b0, cc});     // Reset state.
        compare_value("mdr", 16'h0000, mdr);
        compare_value("busy", 16'h0000, {15'b0, busy});
        compare_value("done", 16'h0000, {15'b0, done});
        for (int n = 0; n < op_count && !timed_out; n++) begin
            drive_random_op();
            issue_op();
            if (!timed_out) begin
                model_and_check();
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: mem_subsystem.f
src/lc3b_pkg.sv
src/wishbone_if.sv
src/mem_stage.sv
src/data_memory.sv
src/mem_subsystem.sv
testbench/mem_subsystem_properties.sv
testbench/tb_mem_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsystem \
    -f mem_subsystem.f \
    -o sim_mem_subsystem

./obj_dir/sim_mem_subsystem | tee sim.log

grep -q "^TEST OK$" sim.log
